// File: include/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// cache line and memory data bus.
`define LINE_BITS 256

// processor word.
`define WORD_BITS 32

`define ADDR_BITS 32

// sets per cache, direct mapped.
`define NUM_SETS 8

`endif

// File: rtl/mem_pkg.sv
`default_nettype none
`include "mem_settings.svh"

package mem_pkg;

    localparam int unsigned WSEL_BITS  = $clog2(`LINE_BITS / `WORD_BITS);
    localparam int unsigned BSEL_BITS  = $clog2(`WORD_BITS / 8);
    localparam int unsigned INDEX_BITS = $clog2(`NUM_SETS);
    localparam int unsigned TAG_BITS   = `ADDR_BITS - INDEX_BITS - WSEL_BITS - BSEL_BITS;

    typedef struct packed {
        logic [TAG_BITS-1:0]   tag;
        logic [INDEX_BITS-1:0] index;
        logic [WSEL_BITS-1:0]  wsel;     // word within the line.
        logic [BSEL_BITS-1:0]  bsel;     // byte within the word.
    } addr_fields_t;

    typedef union packed {
        logic [`ADDR_BITS-1:0] raw;
        addr_fields_t          fields;
    } mem_addr_t;

    typedef struct packed {
        mem_addr_t               addr;
        logic                    read;
        logic                    write;
        logic [`WORD_BITS-1:0]   wdata;
        logic [`WORD_BITS/8-1:0] wmask;  // one bit per byte.
    } cpu_req_t;

    typedef struct packed {
        logic                  resp;
        logic [`WORD_BITS-1:0] rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic [`ADDR_BITS-1:0] addr;     // line aligned.
        logic                  read;
        logic                  write;
        logic [`LINE_BITS-1:0] wdata;
    } line_req_t;

endpackage

`default_nettype wire

// File: rtl/icache.sv
`default_nettype none
`include "mem_settings.svh"

module icache (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire mem_pkg::cpu_req_t     req,
    output mem_pkg::cpu_rsp_t          rsp,
    output mem_pkg::line_req_t         fill,
    input  wire logic [`LINE_BITS-1:0] fill_rdata,
    input  wire logic                  fill_resp
);

    import mem_pkg::*;

    typedef enum logic {
        IDLE,
        FILL
    } state_t;

    state_t state, next_state;

    logic [`NUM_SETS-1:0]  valid;
    logic [TAG_BITS-1:0]   tags  [`NUM_SETS];
    logic [`LINE_BITS-1:0] lines [`NUM_SETS];

    logic [INDEX_BITS-1:0] idx;
    logic [`LINE_BITS-1:0] cur_line;
    logic                  hit;
    logic                  install;

    assign idx      = req.addr.fields.index;
    assign cur_line = lines[idx];
    assign hit      = (state == IDLE) && req.read && valid[idx]
                      && (tags[idx] == req.addr.fields.tag);
    assign install  = (state == FILL) && fill_resp;

    always_comb begin
        rsp.resp  = hit;
        rsp.rdata = cur_line[req.addr.fields.wsel * `WORD_BITS +: `WORD_BITS];
    end

    // fill address comes straight from the held request.
    always_comb begin
        fill       = '0;
        fill.read  = (state == FILL);
        fill.addr  = {req.addr.fields.tag, idx, {(WSEL_BITS + BSEL_BITS){1'b0}}};
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: if (req.read && !hit) next_state = FILL;
            FILL: if (fill_resp) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (install) begin
            valid[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (install) begin
            tags[idx]  <= req.addr.fields.tag;
            lines[idx] <= fill_rdata;    // hits on the next cycle.
        end
    end

endmodule

`default_nettype wire

// File: rtl/dcache.sv
`default_nettype none
`include "mem_settings.svh"

module dcache (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire mem_pkg::cpu_req_t     req,
    output mem_pkg::cpu_rsp_t          rsp,
    output mem_pkg::line_req_t         line,
    input  wire logic [`LINE_BITS-1:0] line_rdata,
    input  wire logic                  line_resp
);

    import mem_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        FILL
    } state_t;

    state_t state, next_state;

    logic [`NUM_SETS-1:0]  valid;
    logic [`NUM_SETS-1:0]  dirty;
    logic [TAG_BITS-1:0]   tags  [`NUM_SETS];
    logic [`LINE_BITS-1:0] lines [`NUM_SETS];

    logic [INDEX_BITS-1:0] idx;
    logic [TAG_BITS-1:0]   tag;
    logic [`LINE_BITS-1:0] cur_line;
    logic [`LINE_BITS-1:0] merged;
    logic                  access;
    logic                  hit;
    logic                  store_hit;
    logic                  install;

    assign idx       = req.addr.fields.index;
    assign tag       = req.addr.fields.tag;
    assign cur_line  = lines[idx];
    assign access    = req.read || req.write;
    assign hit       = (state == IDLE) && access && valid[idx] && (tags[idx] == tag);
    assign store_hit = hit && req.write;
    assign install   = (state == FILL) && line_resp;

    always_comb begin
        rsp.resp  = hit;
        rsp.rdata = cur_line[req.addr.fields.wsel * `WORD_BITS +: `WORD_BITS];
    end

    // byte merge of the store word into the line.
    always_comb begin
        merged = cur_line;
        for (int b = 0; b < `WORD_BITS / 8; b++) begin
            if (req.wmask[b]) begin
                merged[req.addr.fields.wsel * `WORD_BITS + b * 8 +: 8] = req.wdata[b * 8 +: 8];
            end
        end
    end

    always_comb begin
        line = '0;
        case (state)
            WRITEBACK: begin
                line.write = 1'b1;
                line.addr  = {tags[idx], idx, {(WSEL_BITS + BSEL_BITS){1'b0}}}; // victim.
                line.wdata = cur_line;
            end
            FILL: begin
                line.read = 1'b1;
                line.addr = {tag, idx, {(WSEL_BITS + BSEL_BITS){1'b0}}};
            end
            default: ;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (access && !hit) begin
                    if (valid[idx] && dirty[idx]) next_state = WRITEBACK;
                    else                          next_state = FILL;
                end
            end
            WRITEBACK: if (line_resp) next_state = FILL;
            FILL:      if (line_resp) next_state = IDLE;
            default:   next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            dirty <= '0;
        end else if (install) begin
            valid[idx] <= 1'b1;
            dirty[idx] <= 1'b0;          // fresh copy of memory.
        end else if (store_hit) begin
            dirty[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (install) begin
            tags[idx]  <= tag;
            lines[idx] <= line_rdata;
        end else if (store_hit) begin
            lines[idx] <= merged;
        end
    end

endmodule

`default_nettype wire

// File: rtl/arbiter.sv
`default_nettype none
`include "mem_settings.svh"

module arbiter (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire mem_pkg::line_req_t    ifill,
    output logic [`LINE_BITS-1:0]      iline,
    output logic                       iline_resp,
    input  wire mem_pkg::line_req_t    dline,
    output logic [`LINE_BITS-1:0]      dline_rdata,
    output logic                       dline_resp,
    output mem_pkg::line_req_t         pmem_req,
    input  wire logic [`LINE_BITS-1:0] pmem_rdata,
    input  wire logic                  pmem_resp
);

    typedef enum logic [1:0] {
        IDLE,
        SERVE_I,
        SERVE_D
    } state_t;

    state_t state, next_state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // data side wins a tie.
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (dline.read || dline.write) next_state = SERVE_D;
                else if (ifill.read)           next_state = SERVE_I;
            end
            SERVE_I: if (pmem_resp) next_state = IDLE;
            SERVE_D: if (pmem_resp) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_comb begin
        pmem_req    = '0;
        iline       = '0;
        iline_resp  = 1'b0;
        dline_rdata = '0;
        dline_resp  = 1'b0;
        case (state)
            SERVE_I: begin
                pmem_req   = ifill;
                iline      = pmem_rdata;
                iline_resp = pmem_resp;
            end
            SERVE_D: begin
                pmem_req    = dline;
                dline_rdata = pmem_rdata;
                dline_resp  = pmem_resp;
            end
            default: ;                   // port idle.
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/mem_subsystem.sv
`default_nettype none
`include "mem_settings.svh"

module mem_subsystem (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire mem_pkg::cpu_req_t     ireq,
    output mem_pkg::cpu_rsp_t          irsp,
    input  wire mem_pkg::cpu_req_t     dreq,
    output mem_pkg::cpu_rsp_t          drsp,
    output mem_pkg::line_req_t         pmem_req,
    input  wire logic [`LINE_BITS-1:0] pmem_rdata,
    input  wire logic                  pmem_resp
);

    import mem_pkg::*;

    line_req_t             ifill;
    logic [`LINE_BITS-1:0] iline;
    logic                  iline_resp;
    line_req_t             dline;
    logic [`LINE_BITS-1:0] dline_rdata;
    logic                  dline_resp;

    icache u_icache (
        .clk        (clk),
        .rst        (rst),
        .req        (ireq),
        .rsp        (irsp),
        .fill       (ifill),
        .fill_rdata (iline),
        .fill_resp  (iline_resp)
    );

    dcache u_dcache (
        .clk        (clk),
        .rst        (rst),
        .req        (dreq),
        .rsp        (drsp),
        .line       (dline),
        .line_rdata (dline_rdata),
        .line_resp  (dline_resp)
    );

    arbiter u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .ifill       (ifill),
        .iline       (iline),
        .iline_resp  (iline_resp),
        .dline       (dline),
        .dline_rdata (dline_rdata),
        .dline_resp  (dline_resp),
        .pmem_req    (pmem_req),
        .pmem_rdata  (pmem_rdata),
        .pmem_resp   (pmem_resp)
    );

endmodule

`default_nettype wire

// File: tests/mem_subsystem_assert.sv
`default_nettype none

module mem_subsystem_assert (
    input wire logic               clk,
    input wire logic               rst,
    input wire mem_pkg::line_req_t ifill,
    input wire logic               iline_resp,
    input wire mem_pkg::line_req_t dline,
    input wire logic               dline_resp,
    input wire mem_pkg::line_req_t pmem_req,
    input wire logic               pmem_resp
);
    timeunit 1ns;
    timeprecision 1ps;

    pmem_one_dir: assert property (@(posedge clk) disable iff (rst)
        !(pmem_req.read && pmem_req.write))
        else $error("memory port read and write high together");

    // held request keeps its address and data until the response.
    pmem_held: assert property (@(posedge clk) disable iff (rst)
        (pmem_req.read || pmem_req.write) && !pmem_resp
        |=> $stable(pmem_req.addr) && $stable(pmem_req.wdata)
            && $stable(pmem_req.read) && $stable(pmem_req.write))
        else $error("memory request changed before its response");

    iline_resp_held: assert property (@(posedge clk) disable iff (rst)
        iline_resp |-> ifill.read)
        else $error("instruction line response without a pending fill");

    dline_resp_held: assert property (@(posedge clk) disable iff (rst)
        dline_resp |-> (dline.read || dline.write))
        else $error("data line response without a pending transfer");

endmodule

`default_nettype wire

// File: tests/mem_subsystem_tb.sv
`default_nettype none
`include "mem_settings.svh"

module mem_subsystem_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import mem_pkg::*;

    localparam int MAX_CYCLES = 2000;    // ten times the worst case.

    logic                  clk = 1'b0;
    logic                  rst;
    cpu_req_t              ireq;
    cpu_rsp_t              irsp;
    cpu_req_t              dreq;
    cpu_rsp_t              drsp;
    line_req_t             pmem_req;
    logic [`LINE_BITS-1:0] pmem_rdata;
    logic                  pmem_resp;

    logic [`LINE_BITS-1:0] mem_lines [logic [31:0]];
    logic [31:0]           shadow [logic [31:0]];  // words stored by the testbench.
    logic [31:0]           xfer_log [$];
    logic [31:0]           last_write_addr;
    logic [31:0]           rng = 32'h119f;
    int                    hold_cnt = 0;
    int                    reads = 0;
    int                    writes = 0;
    int                    errors = 0;
    int                    tests_ok = 0;
    int                    tests_bad = 0;
    int                    cycles = 0;

    mem_subsystem DUT (
        .clk        (clk),
        .rst        (rst),
        .ireq       (ireq),
        .irsp       (irsp),
        .dreq       (dreq),
        .drsp       (drsp),
        .pmem_req   (pmem_req),
        .pmem_rdata (pmem_rdata),
        .pmem_resp  (pmem_resp)
    );

    bind arbiter mem_subsystem_assert u_assert (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycles);
            $display("test failed");
            $finish;
        end
    end

    function automatic logic [31:0] pattern_word(input logic [31:0] a);
        return {a[31:2], 2'b00} ^ 32'hA5A5_0000;
    endfunction

    function automatic logic [`LINE_BITS-1:0] read_line(input logic [31:0] a);
        logic [`LINE_BITS-1:0] l;
        if (mem_lines.exists(a)) return mem_lines[a];
        for (int w = 0; w < `LINE_BITS / 32; w++) begin
            l[w*32 +: 32] = pattern_word(a + 32'(w * 4));
        end
        return l;
    endfunction

    function automatic logic [31:0] expect_word(input logic [31:0] a);
        logic [31:0] wa;
        wa = {a[31:2], 2'b00};
        if (shadow.exists(wa)) return shadow[wa];
        return pattern_word(wa);
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // memory model, answers after four held cycles.
    always @(negedge clk) begin
        if (rst || pmem_resp) begin
            pmem_resp = 1'b0;
            hold_cnt  = 0;
        end else if (pmem_req.read || pmem_req.write) begin
            hold_cnt++;
            if (hold_cnt == 4) begin
                if (pmem_req.write) begin
                    mem_lines[pmem_req.addr] = pmem_req.wdata;
                    last_write_addr = pmem_req.addr;
                    writes++;
                end else begin
                    pmem_rdata = read_line(pmem_req.addr);
                    reads++;
                end
                xfer_log.push_back(pmem_req.addr);
                pmem_resp = 1'b1;
            end
        end
    end

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic close_test(input string name, input int mark);
        if (errors == mark) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d check(s) wrong", name, errors - mark);
        end
    endtask

    task automatic read_word(input string name, input bit inst, input logic [31:0] a);
        cpu_req_t    r;
        logic [31:0] got;
        r          = '0;
        r.addr.raw = a;
        r.read     = 1'b1;
        @(negedge clk);
        if (inst) ireq = r;
        else      dreq = r;
        @(posedge clk);
        while (!(inst ? irsp.resp : drsp.resp)) @(posedge clk);
        got = inst ? irsp.rdata : drsp.rdata;
        @(negedge clk);
        if (inst) ireq = '0;
        else      dreq = '0;
        check_word(name, expect_word(a), got);
    endtask

    task automatic store(input logic [31:0] a, input logic [31:0] d, input logic [3:0] m);
        logic [31:0] merged;
        merged = expect_word(a);
        for (int b = 0; b < 4; b++) begin
            if (m[b]) merged[b*8 +: 8] = d[b*8 +: 8];
        end
        @(negedge clk);
        dreq          = '0;
        dreq.addr.raw = a;
        dreq.write    = 1'b1;
        dreq.wdata    = d;
        dreq.wmask    = m;
        @(posedge clk);
        while (!drsp.resp) @(posedge clk);
        @(negedge clk);
        dreq = '0;
        shadow[{a[31:2], 2'b00}] = merged;
    endtask

    initial begin
        int          mark;
        int          count_before;
        logic [31:0] a;
        rst        = 1'b1;
        ireq       = '0;
        dreq       = '0;
        pmem_rdata = '0;
        pmem_resp  = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        mark = errors;
        read_word("fetch miss", 1'b1, 32'h0010_1004);
        count_before = reads;
        read_word("fetch hit", 1'b1, 32'h0010_1010);
        assert (reads == count_before) else begin
            $display("[FAIL] fetch hit: expected %0d memory reads, actual %0d",
                     count_before, reads);
            errors++;
        end
        close_test("instruction fetch", mark);

        mark = errors;
        repeat (6) begin
            rng = xorshift(rng);
            read_word("random load", 1'b0, rng & 32'h000F_FFFC);
        end
        close_test("data loads", mark);

        mark = errors;
        rng = xorshift(rng);
        a   = rng & 32'h000F_FFFC;
        rng = xorshift(rng);
        store(a, rng, 4'b0110);
        read_word("load after masked store", 1'b0, a);
        close_test("masked store", mark);

        mark = errors;
        store(32'h0000_4064, 32'hCAFE_F00D, 4'b1111);
        count_before = writes;
        read_word("conflicting load", 1'b0, 32'h0000_8064);    // same set, new tag.
        assert (writes == count_before + 1) else begin
            $display("[FAIL] eviction and writeback: expected %0d line writes, actual %0d",
                     count_before + 1, writes);
            errors++;
        end
        check_word("writeback address", 32'h0000_4060, last_write_addr);
        read_word("reload from memory", 1'b0, 32'h0000_4064);
        close_test("eviction and writeback", mark);

        mark = errors;
        xfer_log.delete();
        fork
            read_word("fetch under contention", 1'b1, 32'h0010_2040);
            read_word("load under contention", 1'b0, 32'h0000_C068);
        join
        check_word("first transfer address", 32'h0000_C060, xfer_log[0]);
        close_test("priority", mark);

        $display("summary: %0d tests ok, %0d tests wrong, %0d check errors",
                 tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
rtl/mem_pkg.sv
rtl/icache.sv
rtl/dcache.sv
rtl/arbiter.sv
rtl/mem_subsystem.sv
tests/mem_subsystem_assert.sv
tests/mem_subsystem_tb.sv
